/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_soc
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Simulation PASSED

.PHONY: all compile run clean

all: run

# Build the simulation executable from the file list
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Run and decide pass or fail from the log
run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Run passed, log in $(LOG)"; \
	else \
	  echo "Run failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/soc_checker.sv */
`timescale 1ns/1ps

module soc_checker (
  input logic             clock_50,
  input logic             rst_n,
  input logic             req,
  input logic             ack,
  input soc_pkg::fs_bus_t bus
);

  int unsigned fail_count = 0;

  ack_needs_req: assert property (@(posedge clock_50) disable iff (!rst_n)
    $rose(ack) |-> $past(req))
  else begin
    fail_count++;
    $error("ack rose with no request pending");
  end

  // Four-phase rule, ack waits for req to drop
  ack_holds: assert property (@(posedge clock_50) disable iff (!rst_n)
    ack && req |=> ack)
  else begin
    fail_count++;
    $error("ack fell while req was still high");
  end

  one_chip: assert property (@(posedge clock_50) disable iff (!rst_n)
    !(!bus.ce0_n && !bus.ce1_n))
  else begin
    fail_count++;
    $error("both chip enables low");
  end

  drive_on_write: assert property (@(posedge clock_50) disable iff (!rst_n)
    bus.data_oe |-> !bus.we_n)
  else begin
    fail_count++;
    $error("data driven outside a write cycle");
  end

  no_adsp_in_ack: assert property (@(posedge clock_50) disable iff (!rst_n)
    ack |-> bus.adsp_n)
  else begin
    fail_count++;
    $error("bus cycle started while ack was high");
  end

endmodule

bind fsbus_ctrl soc_checker u_checker (
  .clock_50 (clock_50),
  .rst_n    (rst_n),
  .req      (req),
  .ack      (ack),
  .bus      (bus)
);

/* dv/ssram_model.sv */
`timescale 1ns/1ps

module ssram_model (
  input  logic                       clock_50,
  input  soc_pkg::fs_bus_t           bus,
  output logic [soc_pkg::DATA_W-1:0] rdata,
  output int unsigned                accesses
);

  // Chip select bit on top of the word address
  logic [soc_pkg::DATA_W-1:0]     mem [logic [soc_pkg::CHIP_SEL_BIT-2:0]];
  logic [soc_pkg::CHIP_SEL_BIT-2:0] key;
  logic [soc_pkg::DATA_W-1:0]     word;
  logic [soc_pkg::DATA_W-1:0]     pipe;
  logic [soc_pkg::DATA_W-1:0]     dout;
  int unsigned                    count = 0;

  always @(posedge clock_50) begin
    // Second pipeline stage
    dout <= pipe;
    if (!bus.adsp_n && !(bus.ce0_n && bus.ce1_n)) begin
      count <= count + 1;
      key = {!bus.ce1_n, bus.addr[soc_pkg::CHIP_SEL_BIT-1:2]};
      // Unwritten words read back a pattern built from the address
      word = mem.exists(key) ? mem[key] : (32'(key) ^ 32'hc5a0_0000);
      if (!bus.we_n) begin
        for (int b = 0; b < soc_pkg::BE_W; b++) begin
          if (!bus.be_n[b]) begin
            word[8*b +: 8] = bus.data_oe ? bus.wdata[8*b +: 8] : 8'hxx;
          end
        end
        mem[key] = word;
      end else begin
        pipe <= word;
      end
    end
  end

  // Data pins only carry a value while the output is enabled
  assign rdata = bus.oe_n ? 'x : dout;
  assign accesses = count;

endmodule

/* dv/tb_soc.sv */
`timescale 1ns/1ps

module tb_soc;

  localparam time PERIOD    = 100ns;
  localparam int  ACK_LIMIT = 10;
  // Accesses issued by all tests together
  localparam int  NUM_ACCESSES    = 33;
  localparam int  WATCHDOG_CYCLES = NUM_ACCESSES * 10 + 100;

  // Active-low gfedcba patterns for 0 to F
  localparam soc_pkg::seg_t SEG_TABLE [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
  };

  logic                                    clock_50;
  logic                                    rst_n;
  logic                                    req;
  soc_pkg::host_req_t                      req_data;
  logic                                    ack;
  logic [soc_pkg::DATA_W-1:0]              rdata;
  soc_pkg::fs_bus_t                        fs_bus;
  logic [soc_pkg::DATA_W-1:0]              fs_rdata;
  soc_pkg::seg_t [soc_pkg::NUM_DIGITS-1:0] hex;
  logic [soc_pkg::LEDR_W-1:0]              ledr;
  logic [soc_pkg::LEDG_W-1:0]              ledg;
  int unsigned                             model_accesses;

  integer seed = 32'hbbb8_956d;
  int     test_errors;
  int     total_errors;
  int     tests_run;
  int     n_writes;
  int     n_reads;

  soc u_soc (
    .clock_50 (clock_50),
    .rst_n    (rst_n),
    .req      (req),
    .req_data (req_data),
    .ack      (ack),
    .rdata    (rdata),
    .fs_bus   (fs_bus),
    .fs_rdata (fs_rdata),
    .hex      (hex),
    .ledr     (ledr),
    .ledg     (ledg)
  );

  ssram_model u_ssram (
    .clock_50 (clock_50),
    .bus      (fs_bus),
    .rdata    (fs_rdata),
    .accesses (model_accesses)
  );

  initial begin
    clock_50 = 1'b0;
    forever #(PERIOD / 2) clock_50 = ~clock_50;
  end

  initial begin
    #(WATCHDOG_CYCLES * PERIOD);
    $display("Watchdog expired, the DUT stopped answering and the run was cut short");
    $display("Simulation FAILED");
    $finish;
  end

  // Inputs change and outputs are read 10 ns after the edge
  task automatic step_cycle;
    @(posedge clock_50);
    #10;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    $display("%-16s %s (%0d errors)", name, (test_errors == 0) ? "ok" : "failed",
             test_errors);
    total_errors += test_errors;
    tests_run++;
    test_errors = 0;
  endtask

  function automatic logic [soc_pkg::ADDR_W-1:0] rand_addr;
    logic [soc_pkg::ADDR_W-1:0] a;
    a = soc_pkg::ADDR_W'($random(seed));
    a[1:0] = 2'b00;
    return a;
  endfunction

  task automatic check_display(input logic write, input logic [soc_pkg::ADDR_W-1:0] addr);
    logic [3:0] nib;
    for (int i = 0; i < soc_pkg::NUM_DIGITS; i++) begin
      // Top digit takes the write flag, the rest the address zero padded
      nib = (i == soc_pkg::NUM_DIGITS - 1) ? {3'b000, write} : 4'(32'(addr) >> (4 * i));
      check_value($sformatf("hex%0d", i), hex[i], SEG_TABLE[nib]);
    end
  endtask

  // One full four-phase transfer, hold keeps req high after ack
  task automatic run_access(input logic write, input logic [3:0] be,
                            input logic [soc_pkg::ADDR_W-1:0] addr,
                            input logic [31:0] wdata, input int hold,
                            output logic [31:0] data);
    int          lat;
    int unsigned seen;
    seen = model_accesses;
    req_data = '{write: write, be: be, addr: addr, wdata: wdata};
    req = 1'b1;
    @(posedge clock_50);
    lat = 0;
    do begin
      step_cycle();
      lat++;
    end while (!ack && lat < ACK_LIMIT);
    assert (ack) else begin
      $display("No ack from the controller for the access to %h", addr);
      test_errors++;
    end
    check_value("ack latency", lat, write ? 2 : 2 + soc_pkg::READ_LAT);
    repeat (hold) begin
      step_cycle();
      check_value("ack held", ack, 1);
    end
    data = rdata;
    req = 1'b0;
    step_cycle();
    check_value("ack before release", ack, 1);
    step_cycle();
    check_value("ack released", ack, 0);
    check_value("bus cycles", model_accesses - seen, 1);
    check_display(write, addr);
    if (write) begin
      n_writes++;
    end else begin
      n_reads++;
    end
  endtask

  task automatic reset_state;
    check_value("ack", ack, 0);
    check_value("strobes", {fs_bus.ce0_n, fs_bus.ce1_n, fs_bus.oe_n, fs_bus.we_n,
                            fs_bus.adsp_n}, 5'h1f);
    check_value("data drive", fs_bus.data_oe, 0);
    for (int i = 0; i < soc_pkg::NUM_DIGITS; i++) begin
      check_value($sformatf("hex%0d", i), hex[i], SEG_TABLE[0]);
    end
    check_value("ledr", ledr, 0);
    check_value("ledg", ledg, 0);
    finish_test("reset_state");
  endtask

  // Same low address in both chips holds separate words
  task automatic write_read_back;
    logic [soc_pkg::ADDR_W-1:0] low;
    logic [soc_pkg::ADDR_W-1:0] high;
    logic [31:0]                d0;
    logic [31:0]                d1;
    logic [31:0]                got;
    for (int i = 0; i < 4; i++) begin
      low = rand_addr();
      low[soc_pkg::CHIP_SEL_BIT] = 1'b0;
      high = low;
      high[soc_pkg::CHIP_SEL_BIT] = 1'b1;
      d0 = $random(seed);
      d1 = $random(seed);
      run_access(1'b1, 4'hf, low, d0, 0, got);
      run_access(1'b1, 4'hf, high, d1, 0, got);
      run_access(1'b0, 4'hf, low, '0, 0, got);
      check_value("chip 0 read", got, d0);
      run_access(1'b0, 4'hf, high, '0, 0, got);
      check_value("chip 1 read", got, d1);
    end
    finish_test("write_read_back");
  endtask

  task automatic byte_enables;
    logic [3:0]                 masks [5] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0110};
    logic [soc_pkg::ADDR_W-1:0] addr;
    logic [31:0]                expect_word;
    logic [31:0]                patch;
    logic [31:0]                got;
    addr = rand_addr();
    expect_word = $random(seed);
    run_access(1'b1, 4'hf, addr, expect_word, 0, got);
    foreach (masks[m]) begin
      patch = $random(seed);
      run_access(1'b1, masks[m], addr, patch, 0, got);
      for (int b = 0; b < 4; b++) begin
        if (masks[m][b]) expect_word[8*b +: 8] = patch[8*b +: 8];
      end
      run_access(1'b0, 4'hf, addr, '0, 0, got);
      check_value($sformatf("merge be=%b", masks[m]), got, expect_word);
    end
    finish_test("byte_enables");
  endtask

  task automatic handshake_rules;
    logic [soc_pkg::ADDR_W-1:0] addr;
    logic [31:0]                word;
    logic [31:0]                got;
    addr = rand_addr();
    word = $random(seed);
    run_access(1'b1, 4'hf, addr, word, 3, got);
    run_access(1'b0, 4'hf, addr, '0, 3, got);
    check_value("read under back-pressure", got, word);
    finish_test("handshake_rules");
  endtask

  task automatic display_digits;
    logic [31:0] got;
    run_access(1'b1, 4'hf, 27'h5a3_c7e4, 32'h1234_5678, 0, got);
    run_access(1'b0, 4'hf, 27'h5a3_c7e4, '0, 0, got);
    check_value("display read", got, 32'h1234_5678);
    run_access(1'b1, 4'h3, 27'h7ff_fffc, 32'hcafe_f00d, 0, got);
    finish_test("display_digits");
  endtask

  // One more read makes the access total odd so the blink bit is set
  task automatic led_counters;
    logic [31:0] got;
    run_access(1'b0, 4'hf, rand_addr(), '0, 0, got);
    check_value("ledr writes", ledr, n_writes);
    check_value("ledg reads", ledg[7:0], n_reads % 256);
    check_value("ledg blink", ledg[8], (n_writes + n_reads) % 2);
    finish_test("led_counters");
  endtask

  initial begin
    rst_n = 1'b0;
    req = 1'b0;
    req_data = '0;
    test_errors = 0;
    total_errors = 0;
    tests_run = 0;
    n_writes = 0;
    n_reads = 0;
    repeat (5) @(posedge clock_50);
    #10;
    rst_n = 1'b1;
    // Internal reset needs three edges to release
    repeat (3) step_cycle();
    reset_state();
    write_read_back();
    byte_enables();
    handshake_rules();
    display_digits();
    led_counters();
    total_errors += u_soc.u_ctrl.u_checker.fail_count;
    $display("Tests run: %0d, errors: %0d", tests_run, total_errors);
    if (total_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* hdl/access_leds.sv */
`timescale 1ns/1ps

module access_leds (
  input  logic                       clock_50,
  input  logic                       rst_n,
  input  soc_pkg::access_t           access,
  output logic [soc_pkg::LEDR_W-1:0] ledr,
  output logic [soc_pkg::LEDG_W-1:0] ledg
);

  logic [soc_pkg::LEDR_W-1:0] wr_cnt;
  logic [soc_pkg::LEDG_W-2:0] rd_cnt;
  logic                       blink;

  // Both counters wrap silently
  always_ff @(posedge clock_50 or negedge rst_n) begin
    if (!rst_n) begin
      wr_cnt <= '0;
      rd_cnt <= '0;
      blink  <= 1'b0;
    end else if (access.done) begin
      if (access.write) begin
        wr_cnt <= wr_cnt + 1'b1;
      end else begin
        rd_cnt <= rd_cnt + 1'b1;
      end
      // Activity blink flips once per access
      blink <= ~blink;
    end
  end

  assign ledr = wr_cnt;
  assign ledg = {blink, rd_cnt};

endmodule

/* hdl/fsbus_ctrl.sv */
`timescale 1ns/1ps

module fsbus_ctrl (
  input  logic                       clock_50,
  input  logic                       rst_n,
  input  logic                       req,
  input  soc_pkg::host_req_t         req_data,
  output logic                       ack,
  output logic [soc_pkg::DATA_W-1:0] rdata,
  output soc_pkg::fs_bus_t           bus,
  input  logic [soc_pkg::DATA_W-1:0] bus_rdata,
  output soc_pkg::access_t           access
);

  typedef enum logic [2:0] {
    st_idle,
    st_addr,
    st_rwait,
    st_capture,
    st_ack,
    st_release
  } state_t;

  state_t                       state;
  logic [soc_pkg::WAIT_W-1:0]   wait_cnt;
  logic                         write_q;
  logic                         done;
  logic                         ce0_n;
  logic                         ce1_n;
  logic                         oe_n;
  logic                         we_n;
  logic                         adsp_n;
  logic                         data_oe;
  logic [soc_pkg::ADDR_W-1:0]   addr_q;
  logic [soc_pkg::BE_W-1:0]     be_n_q;
  logic [soc_pkg::DATA_W-1:0]   wdata_q;

  always_ff @(posedge clock_50 or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      wait_cnt <= '0;
      write_q  <= 1'b0;
      ack      <= 1'b0;
      done     <= 1'b0;
      ce0_n    <= 1'b1;
      ce1_n    <= 1'b1;
      oe_n     <= 1'b1;
      we_n     <= 1'b1;
      adsp_n   <= 1'b1;
      data_oe  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        st_idle: begin
          // Set up the address phase for the next cycle
          if (req) begin
            state   <= st_addr;
            write_q <= req_data.write;
            adsp_n  <= 1'b0;
            ce0_n   <= req_data.addr[soc_pkg::CHIP_SEL_BIT];
            ce1_n   <= ~req_data.addr[soc_pkg::CHIP_SEL_BIT];
            we_n    <= ~req_data.write;
            data_oe <= req_data.write;
          end
        end
        st_addr: begin
          // SSRAM samples address, enables and write data here
          adsp_n   <= 1'b1;
          ce0_n    <= 1'b1;
          ce1_n    <= 1'b1;
          we_n     <= 1'b1;
          data_oe  <= 1'b0;
          wait_cnt <= '0;
          state    <= write_q ? st_capture : st_rwait;
        end
        st_rwait: begin
          wait_cnt <= wait_cnt + 1'b1;
          // Output enable covers the cycles up to capture
          if (wait_cnt == '0) begin
            oe_n <= 1'b0;
          end
          if (wait_cnt == soc_pkg::WAIT_LAST) begin
            state <= st_capture;
          end
        end
        st_capture: begin
          // Read data lands here, writes just recover a cycle
          oe_n  <= 1'b1;
          ack   <= 1'b1;
          done  <= 1'b1;
          state <= st_ack;
        end
        st_ack: begin
          if (!req) begin
            state <= st_release;
          end
        end
        st_release: begin
          ack   <= 1'b0;
          state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock_50) begin
    if (state == st_idle && req) begin
      addr_q  <= req_data.addr;
      be_n_q  <= ~req_data.be;
      wdata_q <= req_data.wdata;
    end
    if (state == st_capture && !write_q) begin
      rdata <= bus_rdata;
    end
  end

  assign bus = '{
    addr:    addr_q,
    be_n:    be_n_q,
    ce0_n:   ce0_n,
    ce1_n:   ce1_n,
    oe_n:    oe_n,
    we_n:    we_n,
    adsp_n:  adsp_n,
    wdata:   wdata_q,
    data_oe: data_oe
  };

  assign access = '{done: done, write: write_q, addr: addr_q};

endmodule

/* hdl/hex_display.sv */
`timescale 1ns/1ps

module hex_display (
  input  logic                                     clock_50,
  input  logic                                     rst_n,
  input  soc_pkg::access_t                         access,
  output soc_pkg::seg_t [soc_pkg::NUM_DIGITS-1:0] hex
);

  logic [soc_pkg::ADDR_W-1:0]        addr_l;
  logic                              write_l;
  logic [soc_pkg::NUM_DIGITS-1:0][3:0] nib;

  function automatic soc_pkg::seg_t seg_decode(input logic [3:0] value);
    case (value)
      4'h0: seg_decode = 7'b1000000;
      4'h1: seg_decode = 7'b1111001;
      4'h2: seg_decode = 7'b0100100;
      4'h3: seg_decode = 7'b0110000;
      4'h4: seg_decode = 7'b0011001;
      4'h5: seg_decode = 7'b0010010;
      4'h6: seg_decode = 7'b0000010;
      4'h7: seg_decode = 7'b1111000;
      4'h8: seg_decode = 7'b0000000;
      4'h9: seg_decode = 7'b0010000;
      4'ha: seg_decode = 7'b0001000;
      4'hb: seg_decode = 7'b0000011;
      4'hc: seg_decode = 7'b1000110;
      4'hd: seg_decode = 7'b0100001;
      4'he: seg_decode = 7'b0000110;
      default: seg_decode = 7'b0001110;
    endcase
  endfunction

  always_ff @(posedge clock_50 or negedge rst_n) begin
    if (!rst_n) begin
      addr_l  <= '0;
      write_l <= 1'b0;
    end else if (access.done) begin
      addr_l  <= access.addr;
      write_l <= access.write;
    end
  end

  // Digit 7 is the write flag, digit 6 carries the top three address bits
  assign nib = {3'b000, write_l, 1'b0, addr_l};

  always_comb begin
    for (int i = 0; i < soc_pkg::NUM_DIGITS; i++) begin
      hex[i] = seg_decode(nib[i]);
    end
  end

endmodule

/* hdl/soc.sv */
`timescale 1ns/1ps

module soc (
  input  logic                            clock_50,
  input  logic                            rst_n,
  input  logic                            req,
  input  soc_pkg::host_req_t              req_data,
  output logic                            ack,
  output logic [soc_pkg::DATA_W-1:0]      rdata,
  output soc_pkg::fs_bus_t                fs_bus,
  input  logic [soc_pkg::DATA_W-1:0]      fs_rdata,
  output soc_pkg::seg_t [soc_pkg::NUM_DIGITS-1:0] hex,
  output logic [soc_pkg::LEDR_W-1:0]      ledr,
  output logic [soc_pkg::LEDG_W-1:0]      ledg
);

  logic [soc_pkg::RST_SYNC_N-1:0] rst_sync;
  logic                           rst_int_n;
  soc_pkg::access_t               access;

  // Reset asserts at once and releases after the chain fills with ones
  always_ff @(posedge clock_50 or negedge rst_n) begin
    if (!rst_n) begin
      rst_sync <= '0;
    end else begin
      rst_sync <= {rst_sync[soc_pkg::RST_SYNC_N-2:0], 1'b1};
    end
  end

  assign rst_int_n = rst_sync[soc_pkg::RST_SYNC_N-1];

  // Host port to SSRAM bus
  fsbus_ctrl u_ctrl (
    .clock_50  (clock_50),
    .rst_n     (rst_int_n),
    .req       (req),
    .req_data  (req_data),
    .ack       (ack),
    .rdata     (rdata),
    .bus       (fs_bus),
    .bus_rdata (fs_rdata),
    .access    (access)
  );

  // Last address on the seven-segment digits
  hex_display u_hex (
    .clock_50 (clock_50),
    .rst_n    (rst_int_n),
    .access   (access),
    .hex      (hex)
  );

  // Access counters on the LEDs
  access_leds u_leds (
    .clock_50 (clock_50),
    .rst_n    (rst_int_n),
    .access   (access),
    .ledr     (ledr),
    .ledg     (ledg)
  );

endmodule

/* hdl/soc_pkg.sv */
package soc_pkg;

  // Flash/SSRAM bus geometry
  localparam int ADDR_W = 27;
  localparam int DATA_W = 32;
  localparam int BE_W = DATA_W / 8;

  // Address bit that selects SSRAM chip 1
  localparam int CHIP_SEL_BIT = 21;

  // Pipelined SSRAM read latency in cycles
  localparam int READ_LAT = 2;
  localparam int WAIT_W = $clog2(READ_LAT + 1);
  localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(READ_LAT - 1);

  // Board resources
  localparam int RST_SYNC_N = 3;
  localparam int LEDR_W = 18;
  localparam int LEDG_W = 9;
  localparam int NUM_DIGITS = 8;

  // Host request, valid while req is high
  typedef struct packed {
    logic              write;
    logic [BE_W-1:0]   be;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } host_req_t;

  // Every bus pin driven by the controller
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [BE_W-1:0]   be_n;
    logic              ce0_n;
    logic              ce1_n;
    logic              oe_n;
    logic              we_n;
    logic              adsp_n;
    logic [DATA_W-1:0] wdata;
    logic              data_oe;
  } fs_bus_t;

  // One completed access
  typedef struct packed {
    logic              done;
    logic              write;
    logic [ADDR_W-1:0] addr;
  } access_t;

  // Segments gfedcba, active low
  typedef logic [6:0] seg_t;

endpackage

/* verilog.f */
hdl/soc_pkg.sv
hdl/fsbus_ctrl.sv
hdl/hex_display.sv
hdl/access_leds.sv
hdl/soc.sv
dv/soc_checker.sv
dv/ssram_model.sv
dv/tb_soc.sv
